//--- xbar_top.f
+incdir+include
rtl/xbar_pkg.sv
rtl/addr_decoder.sv
rtl/init_demux.sv
rtl/tgt_arbiter.sv
rtl/xbar_top.sv
verif/xbar_tb.sv

//--- verif/xbar_tb.sv
// Self-checking testbench for xbar_top; target memories alias on address bits 5:0 only
`default_nettype none

`include "xbar_defines.svh"

module xbar_tb;

  import xbar_pkg::*;

  localparam logic [31:0] SEED       = 32'h2983_eb67;
  localparam int          N_XFER     = 16;
  localparam int          FAIR_N     = 6;
  localparam int          XFER_BOUND = 40;
  // Routing, error, default and contention transfers plus three per fairness round
  localparam int          TOTAL_XFER = 6 * N_XFER + 3 * FAIR_N;
  localparam int          WATCHDOG_CYCLES = (TOTAL_XFER + 10) * XFER_BOUND;
  localparam int          NI = `XBAR_NUM_INIT;
  localparam int          NT = `XBAR_NUM_TGT;

  logic clk_i;
  logic rst_n_i;

  logic     [NI-1:0]                  init_req_i;
  addr_t    [NI-1:0]                  init_addr_i;
  logic     [NI-1:0]                  init_we_i;
  data_t    [NI-1:0]                  init_wdata_i;
  logic     [NI-1:0]                  init_ack_o;
  data_t    [NI-1:0]                  init_rdata_o;
  logic     [NI-1:0]                  init_err_o;
  logic     [NT-1:0]                  tgt_req_o;
  addr_t    [NT-1:0]                  tgt_addr_o;
  logic     [NT-1:0]                  tgt_we_o;
  data_t    [NT-1:0]                  tgt_wdata_o;
  logic     [NT-1:0]                  tgt_ack_i;
  data_t    [NT-1:0]                  tgt_rdata_i;
  addr_t    [`XBAR_NUM_RULES-1:0]     rule_start_i;
  addr_t    [`XBAR_NUM_RULES-1:0]     rule_end_i;
  tgt_idx_t [`XBAR_NUM_RULES-1:0]     rule_tgt_i;
  logic     [NI-1:0]                  default_en_i;
  tgt_idx_t [NI-1:0]                  default_tgt_i;

  logic [31:0] lfsr_q = SEED;
  int          checks = 0;
  int          errors = 0;

  // Target memories and the reference copies
  data_t tgt_mem [NT][64];
  data_t model_mem [NT][64];

  // What each target model last saw
  int    hits [NT];
  addr_t last_addr [NT];
  logic  last_we [NT];

  // Initiators with a routed transfer in flight and where it goes
  logic  busy [NI];
  int    cur_tgt [NI];
  logic  [NI-1:0] ack_prev;
  int    grant_log [NT][$];

  xbar_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      val = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic data_t fill_word(input int t, input int idx);
    return 32'hc0de_0000 ^ (t << 20) ^ (idx * 32'h0001_0101);
  endfunction

  function automatic int total_hits();
    int sum;
    sum = 0;
    for (int t = 0; t < NT; t++) begin
      sum += hits[t];
    end
    return sum;
  endfunction

  // Reference decode by first matching rule and then the per-initiator default
  function automatic void model_route(input int i, input addr_t a, output int t,
                                      output logic err);
    logic found;
    found = 1'b0;
    t = 0;
    err = 1'b1;
    for (int r = 0; r < `XBAR_NUM_RULES; r++) begin
      if (!found && a >= rule_start_i[r] && a < rule_end_i[r]) begin
        found = 1'b1;
        t = rule_tgt_i[r];
        err = 1'b0;
      end
    end
    if (!found && default_en_i[i]) begin
      t = default_tgt_i[i];
      err = 1'b0;
    end
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Memory target with a random ack delay of 0 to 3 cycles
  task automatic serve_target(input int t);
    int dly;
    int idx;
    forever begin
      @(negedge clk_i);
      if (tgt_req_o[t]) begin
        dly = rand_bits(2);
        idx = tgt_addr_o[t][5:0];
        hits[t]++;
        last_addr[t] = tgt_addr_o[t];
        last_we[t] = tgt_we_o[t];
        if (tgt_we_o[t]) begin
          tgt_mem[t][idx] = tgt_wdata_o[t];
        end
        repeat (dly) @(negedge clk_i);
        @(posedge clk_i);
        tgt_ack_i[t] <= 1'b1;
        tgt_rdata_i[t] <= tgt_we_o[t] ? '0 : tgt_mem[t][idx];
        do @(negedge clk_i); while (tgt_req_o[t]);
        @(posedge clk_i);
        tgt_ack_i[t] <= 1'b0;
        tgt_rdata_i[t] <= '0;
      end
    end
  endtask

  // One four-phase transfer; solo adds checks that need a single active initiator
  task automatic do_xfer(input int i, input addr_t a, input logic we, input data_t wd,
                         input logic solo);
    int    et;
    logic  eerr;
    data_t erd;
    int    idx;
    int    hits_et;
    int    hits_all;
    model_route(i, a, et, eerr);
    idx = a[5:0];
    erd = '0;
    if (!eerr && we) begin
      model_mem[et][idx] = wd;
    end else if (!eerr) begin
      erd = model_mem[et][idx];
    end
    hits_et = hits[et];
    hits_all = total_hits();
    @(posedge clk_i);
    init_req_i[i] <= 1'b1;
    init_addr_i[i] <= a;
    init_we_i[i] <= we;
    init_wdata_i[i] <= wd;
    cur_tgt[i] = et;
    busy[i] = !eerr;
    do @(negedge clk_i); while (!init_ack_o[i]);
    check_eq($sformatf("init_err_o[%0d]", i), init_err_o[i], eerr);
    if (eerr || !we) begin
      check_eq($sformatf("init_rdata_o[%0d]", i), init_rdata_o[i], erd);
    end
    if (solo && !eerr) begin
      check_eq($sformatf("request count at tgt_req_o[%0d]", et), hits[et], hits_et + 1);
      check_eq($sformatf("tgt_addr_o[%0d]", et), last_addr[et], a);
      check_eq($sformatf("tgt_we_o[%0d]", et), last_we[et], we);
    end
    @(posedge clk_i);
    init_req_i[i] <= 1'b0;
    do @(negedge clk_i); while (init_ack_o[i]);
    busy[i] = 1'b0;
    if (eerr) begin
      check_eq("request count over all tgt_req_o", total_hits(), hits_all);
    end
  endtask

  // Mapped transfers where initiator i keeps to its own half of each memory
  task automatic run_random(input int i, input int n, input logic fixed, input int ft);
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    addr_t       a;
    for (int k = 0; k < n; k++) begin
      r = fixed ? ft : rand_bits(2) % 3;
      hi = rand_bits(6);
      lo = rand_bits(5);
      a = rule_start_i[r] | addr_t'({hi[5:0], i[0], lo[4:0]});
      do_xfer(i, a, rand_bits(1) != 0, rand_bits(32), 1'b0);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("Test %-12s %s, %0d errors", name,
             (errors == err_before) ? "pass" : "fail", errors - err_before);
  endtask

  // Handshake order and one active transfer per target
  always @(negedge clk_i) begin : watch_handshake
    int n;
    if (rst_n_i) begin
      for (int i = 0; i < NI; i++) begin
        if (init_ack_o[i] && !ack_prev[i]) begin
          assert (init_req_i[i]) else begin
            errors++;
            $display("init_ack_o[%0d] rose while init_req_i was low at %0t", i, $time);
          end
          if (busy[i]) begin
            grant_log[cur_tgt[i]].push_back(i);
          end
        end
        if (!init_ack_o[i] && ack_prev[i]) begin
          assert (!init_req_i[i]) else begin
            errors++;
            $display("init_ack_o[%0d] fell while init_req_i was high at %0t", i, $time);
          end
        end
      end
      for (int t = 0; t < NT; t++) begin
        n = 0;
        for (int i = 0; i < NI; i++) begin
          if (busy[i] && init_ack_o[i] && cur_tgt[i] == t) begin
            n++;
          end
        end
        assert (n <= 1) else begin
          errors++;
          $display("Two initiators served by target %0d at once at %0t", t, $time);
        end
      end
      ack_prev = init_ack_o;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a handshake never completed", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    addr_t wr_addr[$];
    addr_t a;
    int    e0;
    int    lead;
    init_req_i = '0;
    init_addr_i = '0;
    init_we_i = '0;
    init_wdata_i = '0;
    tgt_ack_i = '0;
    tgt_rdata_i = '0;
    default_en_i = '0;
    default_tgt_i = '0;
    ack_prev = '0;
    // Three disjoint windows with a gap at 0x2000 and an empty rule 3
    rule_start_i = {16'h0000, 16'h3000, 16'h1000, 16'h0000};
    rule_end_i   = {16'h0000, 16'h4000, 16'h2000, 16'h1000};
    rule_tgt_i   = {tgt_idx_t'(0), tgt_idx_t'(2), tgt_idx_t'(1), tgt_idx_t'(0)};
    for (int t = 0; t < NT; t++) begin
      hits[t] = 0;
      for (int k = 0; k < 64; k++) begin
        tgt_mem[t][k] = fill_word(t, k);
        model_mem[t][k] = fill_word(t, k);
      end
    end
    for (int i = 0; i < NI; i++) begin
      busy[i] = 1'b0;
      cur_tgt[i] = 0;
    end
    rst_n_i = 1'b0;
    fork
      serve_target(0);
      serve_target(1);
      serve_target(2);
    join_none
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    e0 = errors;
    repeat (8) begin
      @(negedge clk_i);
      check_eq("init_ack_o", init_ack_o, '0);
      check_eq("init_err_o", init_err_o, '0);
      check_eq("tgt_req_o", tgt_req_o, '0);
    end
    end_test("reset", e0);

    e0 = errors;
    for (int k = 0; k < N_XFER; k++) begin
      a = rule_start_i[rand_bits(2) % 3] | addr_t'(rand_bits(12));
      wr_addr.push_back(a);
      do_xfer(0, a, 1'b1, rand_bits(32), 1'b1);
    end
    foreach (wr_addr[k]) begin
      do_xfer(0, wr_addr[k], 1'b0, '0, 1'b1);
    end
    end_test("routing", e0);

    e0 = errors;
    for (int k = 0; k < N_XFER; k++) begin
      do_xfer(0, 16'h2000 | addr_t'(rand_bits(12)), rand_bits(1) != 0, rand_bits(32), 1'b1);
    end
    end_test("decode_err", e0);

    e0 = errors;
    @(posedge clk_i);
    default_en_i[0] <= 1'b1;
    default_tgt_i[0] <= tgt_idx_t'(2);
    // Reference decode must see the new default
    @(negedge clk_i);
    for (int k = 0; k < N_XFER; k++) begin
      do_xfer(0, 16'h2000 | addr_t'(rand_bits(6)), rand_bits(1) != 0, rand_bits(32), 1'b1);
    end
    @(posedge clk_i);
    default_en_i[0] <= 1'b0;
    end_test("default", e0);

    e0 = errors;
    fork
      run_random(0, N_XFER, 1'b0, 0);
      run_random(1, N_XFER, 1'b0, 0);
    join
    // Lead initiator goes alone, then both request target 1 on the same edge
    for (int k = 0; k < FAIR_N; k++) begin
      lead = k % NI;
      run_random(lead, 1, 1'b1, 1);
      grant_log[1].delete();
      fork
        run_random(0, 1, 1'b1, 1);
        run_random(1, 1, 1'b1, 1);
      join
      check_eq("grants at tgt_req_o[1]", grant_log[1].size(), 2);
      if (grant_log[1].size() == 2) begin
        check_eq("first grant at tgt_req_o[1]", grant_log[1][0], (lead + 1) % NI);
      end
    end
    end_test("contention", e0);

    $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/xbar_top.sv
// Full crossbar, every initiator reaches every target; one transfer in flight per initiator
`default_nettype none

`include "xbar_defines.svh"

module xbar_top (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Initiator ports
  input  logic               [`XBAR_NUM_INIT-1:0]   init_req_i,
  input  xbar_pkg::addr_t    [`XBAR_NUM_INIT-1:0]   init_addr_i,
  input  logic               [`XBAR_NUM_INIT-1:0]   init_we_i,
  input  xbar_pkg::data_t    [`XBAR_NUM_INIT-1:0]   init_wdata_i,
  output logic               [`XBAR_NUM_INIT-1:0]   init_ack_o,
  output xbar_pkg::data_t    [`XBAR_NUM_INIT-1:0]   init_rdata_o,
  output logic               [`XBAR_NUM_INIT-1:0]   init_err_o,
  // Target ports
  output logic               [`XBAR_NUM_TGT-1:0]    tgt_req_o,
  output xbar_pkg::addr_t    [`XBAR_NUM_TGT-1:0]    tgt_addr_o,
  output logic               [`XBAR_NUM_TGT-1:0]    tgt_we_o,
  output xbar_pkg::data_t    [`XBAR_NUM_TGT-1:0]    tgt_wdata_o,
  input  logic               [`XBAR_NUM_TGT-1:0]    tgt_ack_i,
  input  xbar_pkg::data_t    [`XBAR_NUM_TGT-1:0]    tgt_rdata_i,
  // Shared address map
  input  xbar_pkg::addr_t    [`XBAR_NUM_RULES-1:0]  rule_start_i,
  input  xbar_pkg::addr_t    [`XBAR_NUM_RULES-1:0]  rule_end_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_RULES-1:0]  rule_tgt_i,
  // Default target per initiator
  input  logic               [`XBAR_NUM_INIT-1:0]   default_en_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_INIT-1:0]   default_tgt_i
);

  import xbar_pkg::*;

  // Demux side, indexed initiator first
  logic  [`XBAR_NUM_INIT-1:0][`XBAR_NUM_TGT-1:0] fwd_req;
  logic  [`XBAR_NUM_INIT-1:0][`XBAR_NUM_TGT-1:0] fwd_ack;
  addr_t [`XBAR_NUM_INIT-1:0]                    fwd_addr;
  logic  [`XBAR_NUM_INIT-1:0]                    fwd_we;
  data_t [`XBAR_NUM_INIT-1:0]                    fwd_wdata;

  // Arbiter side, indexed target first
  logic  [`XBAR_NUM_TGT-1:0][`XBAR_NUM_INIT-1:0] arb_req;
  logic  [`XBAR_NUM_TGT-1:0][`XBAR_NUM_INIT-1:0] arb_ack;
  data_t [`XBAR_NUM_TGT-1:0]                     arb_rdata;

  for (genvar i = 0; i < `XBAR_NUM_INIT; i++) begin : gen_init
    init_demux u_init_demux (
      .clk_i,
      .rst_n_i,
      .init_req_i    (init_req_i[i]),
      .init_addr_i   (init_addr_i[i]),
      .init_we_i     (init_we_i[i]),
      .init_wdata_i  (init_wdata_i[i]),
      .init_ack_o    (init_ack_o[i]),
      .init_rdata_o  (init_rdata_o[i]),
      .init_err_o    (init_err_o[i]),
      .rule_start_i  (rule_start_i),
      .rule_end_i    (rule_end_i),
      .rule_tgt_i    (rule_tgt_i),
      .default_en_i  (default_en_i[i]),
      .default_tgt_i (default_tgt_i[i]),
      .fwd_req_o     (fwd_req[i]),
      .fwd_addr_o    (fwd_addr[i]),
      .fwd_we_o      (fwd_we[i]),
      .fwd_wdata_o   (fwd_wdata[i]),
      .fwd_ack_i     (fwd_ack[i]),
      .fwd_rdata_i   (arb_rdata)
    );
  end

  // Swap the request and ack matrices between the two sides
  for (genvar i = 0; i < `XBAR_NUM_INIT; i++) begin : gen_cross_init
    for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_cross_tgt
      assign arb_req[t][i] = fwd_req[i][t];
      assign fwd_ack[i][t] = arb_ack[t][i];
    end
  end

  for (genvar t = 0; t < `XBAR_NUM_TGT; t++) begin : gen_tgt
    tgt_arbiter u_tgt_arbiter (
      .clk_i,
      .rst_n_i,
      .req_i       (arb_req[t]),
      .addr_i      (fwd_addr),
      .we_i        (fwd_we),
      .wdata_i     (fwd_wdata),
      .ack_o       (arb_ack[t]),
      .rdata_o     (arb_rdata[t]),
      .tgt_req_o   (tgt_req_o[t]),
      .tgt_addr_o  (tgt_addr_o[t]),
      .tgt_we_o    (tgt_we_o[t]),
      .tgt_wdata_o (tgt_wdata_o[t]),
      .tgt_ack_i   (tgt_ack_i[t]),
      .tgt_rdata_i (tgt_rdata_i[t])
    );
  end

endmodule

`default_nettype wire

//--- rtl/tgt_arbiter.sv
// Round-robin over initiators, one grant held for a full four-phase exchange on the target
`default_nettype none

`include "xbar_defines.svh"

module tgt_arbiter (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // From the initiator demuxes
  input  logic            [`XBAR_NUM_INIT-1:0]    req_i,
  input  xbar_pkg::addr_t [`XBAR_NUM_INIT-1:0]    addr_i,
  input  logic            [`XBAR_NUM_INIT-1:0]    we_i,
  input  xbar_pkg::data_t [`XBAR_NUM_INIT-1:0]    wdata_i,
  output logic            [`XBAR_NUM_INIT-1:0]    ack_o,
  output xbar_pkg::data_t                         rdata_o,
  // Target port
  output logic                                    tgt_req_o,
  output xbar_pkg::addr_t                         tgt_addr_o,
  output logic                                    tgt_we_o,
  output xbar_pkg::data_t                         tgt_wdata_o,
  input  logic                                    tgt_ack_i,
  input  xbar_pkg::data_t                         tgt_rdata_i
);

  import xbar_pkg::*;

  arb_state_t state_q;
  arb_state_t state_d;

  // Current grant and the initiator with highest priority next time
  init_idx_t grant_q;
  init_idx_t ptr_q;
  init_idx_t pick;

  // Rotating search starting at the pointer
  always_comb begin
    int unsigned cand;
    pick = ptr_q;
    for (int k = `XBAR_NUM_INIT - 1; k >= 0; k--) begin
      cand = (int'(ptr_q) + k) % `XBAR_NUM_INIT;
      if (req_i[cand]) begin
        pick = init_idx_t'(cand);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ARB_IDLE: begin
        if (|req_i) begin
          state_d = ARB_BUSY;
        end
      end
      ARB_BUSY: begin
        if (!req_i[grant_q]) begin
          state_d = ARB_DRAIN;
        end
      end
      // Hold the grant until the target has dropped its ack
      ARB_DRAIN: begin
        if (!tgt_ack_i) begin
          state_d = ARB_IDLE;
        end
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
      ptr_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ARB_IDLE && |req_i) begin
        grant_q <= pick;
      end
      // Next search starts just past the initiator that was served
      if (state_q == ARB_DRAIN && !tgt_ack_i) begin
        ptr_q <= (grant_q == init_idx_t'(`XBAR_NUM_INIT - 1)) ? '0 : grant_q + 1'b1;
      end
    end
  end

  assign tgt_req_o   = (state_q == ARB_BUSY) && req_i[grant_q];
  assign tgt_addr_o  = addr_i[grant_q];
  assign tgt_we_o    = we_i[grant_q];
  assign tgt_wdata_o = wdata_i[grant_q];

  // Ack goes back only to the granted initiator
  always_comb begin
    ack_o = '0;
    if (state_q != ARB_IDLE) begin
      ack_o[grant_q] = tgt_ack_i;
    end
  end

  assign rdata_o = (state_q != ARB_IDLE) ? tgt_rdata_i : '0;

endmodule

`default_nettype wire

//--- rtl/init_demux.sv
// One transfer in flight per initiator; map and defaults must stay stable while req is high
`default_nettype none

`include "xbar_defines.svh"

module init_demux (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Initiator port
  input  logic                                      init_req_i,
  input  xbar_pkg::addr_t                           init_addr_i,
  input  logic                                      init_we_i,
  input  xbar_pkg::data_t                           init_wdata_i,
  output logic                                      init_ack_o,
  output xbar_pkg::data_t                           init_rdata_o,
  output logic                                      init_err_o,
  // Address map and default target
  input  xbar_pkg::addr_t    [`XBAR_NUM_RULES-1:0]  rule_start_i,
  input  xbar_pkg::addr_t    [`XBAR_NUM_RULES-1:0]  rule_end_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_RULES-1:0]  rule_tgt_i,
  input  logic                                      default_en_i,
  input  xbar_pkg::tgt_idx_t                        default_tgt_i,
  // Towards the target arbiters
  output logic               [`XBAR_NUM_TGT-1:0]    fwd_req_o,
  output xbar_pkg::addr_t                           fwd_addr_o,
  output logic                                      fwd_we_o,
  output xbar_pkg::data_t                           fwd_wdata_o,
  input  logic               [`XBAR_NUM_TGT-1:0]    fwd_ack_i,
  input  xbar_pkg::data_t    [`XBAR_NUM_TGT-1:0]    fwd_rdata_i
);

  import xbar_pkg::*;

  demux_state_t state_q;
  demux_state_t state_d;

  // Decoder result for the current request
  tgt_idx_t dec_tgt;
  logic     dec_err;

  // Request fields captured when leaving IDLE
  tgt_idx_t tgt_q;
  addr_t    addr_q;
  logic     we_q;
  data_t    wdata_q;

  addr_decoder u_addr_decoder (
    .addr_i        (init_addr_i),
    .rule_start_i  (rule_start_i),
    .rule_end_i    (rule_end_i),
    .rule_tgt_i    (rule_tgt_i),
    .default_en_i  (default_en_i),
    .default_tgt_i (default_tgt_i),
    .tgt_o         (dec_tgt),
    .dec_err_o     (dec_err)
  );

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      DEMUX_IDLE: begin
        if (init_req_i) begin
          state_d = dec_err ? DEMUX_ERR : DEMUX_ROUTE;
        end
      end
      // Requester drops req only after it has seen the target ack
      DEMUX_ROUTE: begin
        if (!init_req_i) begin
          state_d = DEMUX_DRAIN;
        end
      end
      // Local error response ends as soon as req is gone
      DEMUX_ERR: begin
        if (!init_req_i) begin
          state_d = DEMUX_IDLE;
        end
      end
      DEMUX_DRAIN: begin
        if (!fwd_ack_i[tgt_q]) begin
          state_d = DEMUX_IDLE;
        end
      end
      default: state_d = DEMUX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= DEMUX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == DEMUX_IDLE && init_req_i) begin
      tgt_q   <= dec_tgt;
      addr_q  <= init_addr_i;
      we_q    <= init_we_i;
      wdata_q <= init_wdata_i;
    end
  end

  // Handshake steering, only the latched target sees a request bit
  always_comb begin
    fwd_req_o    = '0;
    init_ack_o   = 1'b0;
    init_err_o   = 1'b0;
    init_rdata_o = '0;
    unique case (state_q)
      DEMUX_ROUTE: begin
        fwd_req_o[tgt_q] = init_req_i;
        init_ack_o       = fwd_ack_i[tgt_q];
        init_rdata_o     = fwd_rdata_i[tgt_q];
      end
      DEMUX_DRAIN: begin
        init_ack_o   = fwd_ack_i[tgt_q];
        init_rdata_o = fwd_rdata_i[tgt_q];
      end
      DEMUX_ERR: begin
        init_ack_o = 1'b1;
        init_err_o = 1'b1;
      end
      default: ;
    endcase
  end

  assign fwd_addr_o  = addr_q;
  assign fwd_we_o    = we_q;
  assign fwd_wdata_o = wdata_q;

endmodule

`default_nettype wire

//--- rtl/addr_decoder.sv
// Purely combinational; rule targets must be below XBAR_NUM_TGT and end addresses are exclusive
`default_nettype none

`include "xbar_defines.svh"

module addr_decoder (
  input  xbar_pkg::addr_t                         addr_i,
  input  xbar_pkg::addr_t  [`XBAR_NUM_RULES-1:0]  rule_start_i,
  input  xbar_pkg::addr_t  [`XBAR_NUM_RULES-1:0]  rule_end_i,
  input  xbar_pkg::tgt_idx_t [`XBAR_NUM_RULES-1:0] rule_tgt_i,
  input  logic                                    default_en_i,
  input  xbar_pkg::tgt_idx_t                      default_tgt_i,
  output xbar_pkg::tgt_idx_t                      tgt_o,
  output logic                                    dec_err_o
);

  import xbar_pkg::*;

  // Per rule hit flags and the target of the winning rule
  logic [`XBAR_NUM_RULES-1:0] rule_hit;
  logic                       any_hit;
  tgt_idx_t                   hit_tgt;

  // Range compare, start inclusive and end exclusive
  always_comb begin
    for (int r = 0; r < `XBAR_NUM_RULES; r++) begin
      rule_hit[r] = (addr_i >= rule_start_i[r]) && (addr_i < rule_end_i[r]);
    end
  end

  // Priority pick, scanning from the top so the lowest index is written last
  always_comb begin
    hit_tgt = '0;
    for (int r = `XBAR_NUM_RULES - 1; r >= 0; r--) begin
      if (rule_hit[r]) begin
        hit_tgt = rule_tgt_i[r];
      end
    end
  end

  assign any_hit = |rule_hit;

  // Unmapped addresses fall back to the default target when it is enabled
  always_comb begin
    if (any_hit) begin
      tgt_o     = hit_tgt;
      dec_err_o = 1'b0;
    end else if (default_en_i) begin
      tgt_o     = default_tgt_i;
      dec_err_o = 1'b0;
    end else begin
      // Target number is don't care here, keep it at zero
      tgt_o     = '0;
      dec_err_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/xbar_pkg.sv
// Shared crossbar types; widths follow the macros in xbar_defines.svh at compile time
`default_nettype none

`include "xbar_defines.svh"

package xbar_pkg;

  // Address and data words as seen on every port
  typedef logic [`XBAR_ADDR_W-1:0] addr_t;
  typedef logic [`XBAR_DATA_W-1:0] data_t;

  // Port numbers, at least one bit wide even for a single port
  typedef logic [((`XBAR_NUM_TGT > 1) ? $clog2(`XBAR_NUM_TGT) : 1)-1:0] tgt_idx_t;
  typedef logic [((`XBAR_NUM_INIT > 1) ? $clog2(`XBAR_NUM_INIT) : 1)-1:0] init_idx_t;

  // Initiator side routing FSM
  typedef enum logic [1:0] {
    DEMUX_IDLE,
    DEMUX_ROUTE,
    DEMUX_ERR,
    DEMUX_DRAIN
  } demux_state_t;

  // Target side grant FSM
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_BUSY,
    ARB_DRAIN
  } arb_state_t;

endpackage

`default_nettype wire

//--- include/xbar_defines.svh
// Crossbar sizes; index types in the package need XBAR_NUM_TGT and XBAR_NUM_INIT of at least 1
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Number of initiator ports, each with its own decoder and demux
`define XBAR_NUM_INIT 2

// Number of target ports, each with its own round-robin arbiter
`define XBAR_NUM_TGT 3

// Address width of every port
`define XBAR_ADDR_W 16

// Read and write data width of every port
`define XBAR_DATA_W 32

// Entries in the shared address map
// Lowest matching index wins, so overlapping rules are allowed
`define XBAR_NUM_RULES 4

`endif
